//--- dcache_mem.f
verilog/dcache_cfg_pkg.sv
verilog/dcache_types_pkg.sv
verilog/dcache_port_arb.sv
verilog/dcache_bank_ctrl.sv
verilog/dcache_sram.sv
verilog/dcache_hit_sel.sv
verilog/dcache_mem.sv
tests/tb_clk_gen.sv
tests/tb_dcache_mem.sv

//--- run.sh
#!/bin/sh
# build and run the dcache_mem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f dcache_mem.f --top-module tb_dcache_mem -o sim_dcache_mem

./obj_dir/sim_dcache_mem > sim.log 2>&1
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
  exit 1
fi
exit 0

//--- tests/tb_clk_gen.sv
////////////////////////////////////////
// testbench clock and reset
// 20 ns clock, reset low for 16 cycles
////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  always #10 clk_o = ~clk_o;

endmodule

//--- tests/tb_dcache_mem.sv
////////////////////////////////////////
// dcache_mem testbench
// refills, lookups, word writes, port
// arbitration and bank collisions, checked
// against a shadow model of the arrays
////////////////////////////////////////

`timescale 1ns/1ps

module tb_dcache_mem;

  import dcache_cfg_pkg::*;
  import dcache_types_pkg::*;

  // about 60 reads and writes of at most 25 cycles each plus margin
  localparam int MAX_CYCLES = 2000;

  logic clk;
  logic rst_n;
  rd_port_t [NUM_PORTS-1:0]                  rd_port;
  logic [NUM_PORTS-1:0][TAG_WIDTH-1:0]       rd_tag;
  cl_wr_t                                    cl_wr;
  word_wr_t                                  word_wr;
  logic [NUM_PORTS-1:0]                      rd_ack;
  logic [NUM_WAYS-1:0]                       rd_vld_bits;
  logic [NUM_WAYS-1:0]                       rd_hit_oh;
  logic [WORD_WIDTH-1:0]                     rd_data;
  logic                                      wr_ack;

  // shadow model per set and way
  logic [TAG_WIDTH-1:0]  m_tag  [NUM_SETS][NUM_WAYS];
  logic                  m_vld  [NUM_SETS][NUM_WAYS];
  logic [WORD_WIDTH-1:0] m_data [NUM_SETS][NUM_WAYS][NUM_BANKS];

  // expected values for the assertions below
  logic                  chk_en;
  logic                  chk_data;
  logic [NUM_WAYS-1:0]   exp_hit;
  logic [NUM_WAYS-1:0]   exp_vld;
  logic [WORD_WIDTH-1:0] exp_data;
  logic                  ack_chk;
  logic [NUM_PORTS-1:0]  exp_ack;
  logic                  wr_chk;
  logic                  exp_wr_ack;
  logic                  rr_chk;
  logic [NUM_PORTS-1:0]  prev_ack;

  logic [31:0] rng_state;
  string       test_name;
  int          errors;
  int          err_mark;
  int          n_pass;
  int          n_fail;
  int          cycles;
  logic [IDX_WIDTH-1:0] r_idx [8];
  int                   r_way [8];
  logic [TAG_WIDTH-1:0] r_tag [8];

  tb_clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dcache_mem i_dcache_mem (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .rd_port_i     (rd_port),
    .rd_tag_i      (rd_tag),
    .cl_wr_i       (cl_wr),
    .word_wr_i     (word_wr),
    .rd_ack_o      (rd_ack),
    .rd_vld_bits_o (rd_vld_bits),
    .rd_hit_oh_o   (rd_hit_oh),
    .rd_data_o     (rd_data),
    .wr_ack_o      (wr_ack)
  );

  ////////////////////////////////////////
  // checks sampled mid cycle
  ////////////////////////////////////////

  a_hit: assert property (@(negedge clk) disable iff (!rst_n) chk_en |-> rd_hit_oh == exp_hit)
    else begin
      errors++;
      $display("mismatch %s hit vector expected %h actual %h", test_name, exp_hit, rd_hit_oh);
    end

  a_vld: assert property (@(negedge clk) disable iff (!rst_n) chk_en |-> rd_vld_bits == exp_vld)
    else begin
      errors++;
      $display("mismatch %s valid bits expected %h actual %h", test_name, exp_vld, rd_vld_bits);
    end

  a_data: assert property (@(negedge clk) disable iff (!rst_n)
    chk_en && chk_data |-> rd_data == exp_data)
    else begin
      errors++;
      $display("mismatch %s data expected %h actual %h", test_name, exp_data, rd_data);
    end

  a_ack: assert property (@(negedge clk) disable iff (!rst_n) ack_chk |-> rd_ack == exp_ack)
    else begin
      errors++;
      $display("mismatch %s read ack expected %b actual %b", test_name, exp_ack, rd_ack);
    end

  a_wr_ack: assert property (@(negedge clk) disable iff (!rst_n) wr_chk |-> wr_ack == exp_wr_ack)
    else begin
      errors++;
      $display("mismatch %s write ack expected %b actual %b", test_name, exp_wr_ack, wr_ack);
    end

  a_stall: assert property (@(negedge clk) disable iff (!rst_n) cl_wr.vld |-> rd_ack == '0)
    else begin
      errors++;
      $display("%s: a read was acked during a refill", test_name);
    end

  // each grant moves on to the next requesting port
  a_rotate: assert property (@(negedge clk) disable iff (!rst_n)
    rr_chk && $past(rr_chk) |-> rd_ack == rotate_ack(prev_ack))
    else begin
      errors++;
      $display("mismatch %s grant expected %b actual %b", test_name, rotate_ack(prev_ack),
               rd_ack);
    end

  // grant of the cycle that just ended
  always @(posedge clk) begin
    prev_ack <= rd_ack;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles in %s", cycles, test_name);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [NUM_PORTS-1:0] rotate_ack(input logic [NUM_PORTS-1:0] ack);
    return {ack[NUM_PORTS-2:0], ack[NUM_PORTS-1]};
  endfunction

  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic end_test();
    if (errors == err_mark) begin
      n_pass++;
      $display("test %s ok", test_name);
    end else begin
      n_fail++;
      $display("test %s failed with %0d errors", test_name, errors - err_mark);
    end
  endtask

  // refill one way while port 0 requests a read that must be held off
  task automatic refill(input logic [IDX_WIDTH-1:0] idx, input int way,
                        input logic [TAG_WIDTH-1:0] tag, input logic v);
    cache_line_u line;
    for (int b = 0; b < NUM_BANKS; b++) begin
      line.words[b] = {next_rand(), next_rand()};
    end
    @(posedge clk);
    cl_wr.vld         <= 1'b1;
    cl_wr.we          <= NUM_WAYS'(1 << way);
    cl_wr.tag         <= tag;
    cl_wr.idx         <= idx;
    cl_wr.vld_bits    <= {NUM_WAYS{v}};
    cl_wr.data        <= line;
    cl_wr.be.bits     <= '1;
    rd_port[0].req    <= 1'b1;
    rd_port[0].idx    <= idx;
    @(posedge clk);
    cl_wr.vld      <= 1'b0;
    cl_wr.we       <= '0;
    rd_port[0].req <= 1'b0;
    m_tag[idx][way] = tag;
    m_vld[idx][way] = v;
    for (int b = 0; b < NUM_BANKS; b++) begin
      m_data[idx][way][b] = line.words[b];
    end
  endtask

  task automatic merge_word(input logic [IDX_WIDTH-1:0] idx, input int way,
                            input logic [OFF_WIDTH-1:0] off, input logic [WORD_WIDTH-1:0] data,
                            input logic [WORD_BYTES-1:0] be);
    for (int i = 0; i < WORD_BYTES; i++) begin
      if (be[i]) begin
        m_data[idx][way][off[OFF_WIDTH-1:WORD_ALIGN]][i*8 +: 8] = data[i*8 +: 8];
      end
    end
  endtask

  task automatic lookup(input int p, input logic [IDX_WIDTH-1:0] idx,
                        input logic [OFF_WIDTH-1:0] off, input logic [TAG_WIDTH-1:0] tag,
                        input logic tonly);
    int                    waited;
    logic [NUM_WAYS-1:0]   hit;
    logic [NUM_WAYS-1:0]   vld;
    logic [WORD_WIDTH-1:0] word;
    waited = 0;
    @(posedge clk);
    rd_port[p].req      <= 1'b1;
    rd_port[p].tag_only <= tonly;
    rd_port[p].prio     <= 1'b0;
    rd_port[p].idx      <= idx;
    rd_port[p].off      <= off;
    @(negedge clk);
    while (!rd_ack[p] && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (!rd_ack[p]) begin
      errors++;
      $display("%s: read on port %0d was never acked", test_name, p);
    end
    hit  = '0;
    word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      vld[w] = m_vld[idx][w];
      if (m_vld[idx][w] && m_tag[idx][w] == tag) begin
        hit[w] = 1'b1;
        word   = m_data[idx][w][off[OFF_WIDTH-1:WORD_ALIGN]];
      end
    end
    @(posedge clk);
    rd_port[p].req <= 1'b0;
    rd_tag[p]      <= tag;
    chk_en         <= rd_ack[p];
    chk_data       <= ~tonly;
    exp_hit        <= hit;
    exp_vld        <= vld;
    exp_data       <= word;
    @(posedge clk);
    chk_en <= 1'b0;
  endtask

  task automatic write_word(input logic [IDX_WIDTH-1:0] idx, input int way,
                            input logic [OFF_WIDTH-1:0] off, input logic [WORD_WIDTH-1:0] data,
                            input logic [WORD_BYTES-1:0] be);
    int waited;
    waited = 0;
    @(posedge clk);
    word_wr.req  <= NUM_WAYS'(1 << way);
    word_wr.idx  <= idx;
    word_wr.off  <= off;
    word_wr.data <= data;
    word_wr.be   <= be;
    @(negedge clk);
    while (!wr_ack && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (wr_ack) begin
      merge_word(idx, way, off, data, be);
    end else begin
      errors++;
      $display("%s: word write was never acked", test_name);
    end
    @(posedge clk);
    word_wr.req <= '0;
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    logic [WORD_WIDTH-1:0] wdata;
    logic [WORD_BYTES-1:0] wbe;
    rd_port    = '0;
    rd_tag     = '0;
    cl_wr      = '0;
    word_wr    = '0;
    chk_en     = 1'b0;
    chk_data   = 1'b0;
    exp_hit    = '0;
    exp_vld    = '0;
    exp_data   = '0;
    ack_chk    = 1'b0;
    exp_ack    = '0;
    wr_chk     = 1'b0;
    exp_wr_ack = 1'b0;
    rr_chk     = 1'b0;
    prev_ack   = '0;
    rng_state  = 32'he06c_8be6;
    errors     = 0;
    n_pass     = 0;
    n_fail     = 0;
    cycles     = 0;
    test_name  = "reset";
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_tag[s][w] = '0;
        m_vld[s][w] = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
          m_data[s][w][b] = '0;
        end
      end
    end
    @(posedge rst_n);
    repeat (2) @(posedge clk);

    start_test("refill_hit");
    for (int i = 0; i < 8; i++) begin
      r_idx[i] = IDX_WIDTH'(next_rand());
      r_way[i] = int'(next_rand() % NUM_WAYS);
      r_tag[i] = TAG_WIDTH'(next_rand());
      refill(r_idx[i], r_way[i], r_tag[i], 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        lookup(i % NUM_PORTS, r_idx[i], OFF_WIDTH'(b * WORD_BYTES), r_tag[i], 1'b0);
      end
    end
    end_test();

    start_test("miss");
    for (int i = 0; i < 4; i++) begin
      lookup(i % NUM_PORTS, r_idx[i], '0, r_tag[i] ^ 8'h5a, 1'b0);
    end
    refill(r_idx[0], r_way[0], r_tag[0], 1'b0);
    lookup(2, r_idx[0], 5'd8, r_tag[0], 1'b0);
    end_test();

    start_test("word_write");
    for (int i = 1; i < 5; i++) begin
      wdata = {next_rand(), next_rand()};
      wbe   = WORD_BYTES'(next_rand());
      write_word(r_idx[i], r_way[i], OFF_WIDTH'(i * WORD_BYTES), wdata, wbe);
      lookup(1, r_idx[i], OFF_WIDTH'(i * WORD_BYTES), m_tag[r_idx[i]][r_way[i]], 1'b0);
    end
    end_test();

    start_test("arbitration");
    @(posedge clk);
    rd_port[0].req  <= 1'b1;
    rd_port[0].prio <= 1'b0;
    rd_port[1].req  <= 1'b1;
    rd_port[1].prio <= 1'b1;
    rd_port[2].req  <= 1'b1;
    rd_port[2].prio <= 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      rd_port[p].tag_only <= 1'b1;
    end
    ack_chk <= 1'b1;
    exp_ack <= 3'b010;
    repeat (3) @(posedge clk);
    rd_port[1].prio <= 1'b0;
    ack_chk         <= 1'b0;
    rr_chk          <= 1'b1;
    repeat (7) @(posedge clk);
    rr_chk <= 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      rd_port[p].req <= 1'b0;
    end
    end_test();

    start_test("bank_collision");
    wdata = {next_rand(), next_rand()};
    wbe   = WORD_BYTES'(next_rand());
    @(posedge clk);
    rd_port[0] <= '{req: 1'b1, tag_only: 1'b0, prio: 1'b0, idx: r_idx[5], off: 5'd16};
    word_wr    <= '{req: NUM_WAYS'(1 << r_way[5]), idx: r_idx[5], off: 5'd16,
                    data: wdata, be: wbe};
    ack_chk    <= 1'b1;
    exp_ack    <= 3'b001;
    wr_chk     <= 1'b1;
    exp_wr_ack <= 1'b0;
    // the refused write is retried once the read has gone
    @(posedge clk);
    rd_port[0].req <= 1'b0;
    exp_ack        <= 3'b000;
    exp_wr_ack     <= 1'b1;
    merge_word(r_idx[5], r_way[5], 5'd16, wdata, wbe);
    @(posedge clk);
    wdata = {next_rand(), next_rand()};
    rd_port[0]   <= '{req: 1'b1, tag_only: 1'b0, prio: 1'b0, idx: r_idx[5], off: 5'd0};
    word_wr.off  <= 5'd24;
    word_wr.data <= wdata;
    exp_ack      <= 3'b001;
    merge_word(r_idx[5], r_way[5], 5'd24, wdata, wbe);
    @(posedge clk);
    wdata = {next_rand(), next_rand()};
    rd_port[0]   <= '{req: 1'b1, tag_only: 1'b1, prio: 1'b0, idx: r_idx[5], off: 5'd8};
    word_wr.off  <= 5'd8;
    word_wr.data <= wdata;
    merge_word(r_idx[5], r_way[5], 5'd8, wdata, wbe);
    @(posedge clk);
    rd_port[0].req <= 1'b0;
    word_wr.req    <= '0;
    ack_chk        <= 1'b0;
    wr_chk         <= 1'b0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      lookup(2, r_idx[5], OFF_WIDTH'(b * WORD_BYTES), m_tag[r_idx[5]][r_way[5]], 1'b0);
    end
    end_test();

    start_test("tag_only");
    for (int i = 0; i < 8; i++) begin
      lookup(i % NUM_PORTS, r_idx[i], OFF_WIDTH'(next_rand()), r_tag[i], 1'b1);
    end
    end_test();

    repeat (2) @(posedge clk);
    $display("tests passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0 && errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- verilog/dcache_bank_ctrl.sv
////////////////////////////////////////
// dcache bank control
// builds the command of every data bank and
// the tag array access, refuses word writes
// that hit the bank of the granted read
////////////////////////////////////////

`timescale 1ns/1ps

module dcache_bank_ctrl (
  input  dcache_types_pkg::rd_port_t [dcache_cfg_pkg::NUM_PORTS-1:0]  rd_port_i,
  input  logic                                                        rd_acked_i,
  input  logic [dcache_cfg_pkg::PORT_SEL_WIDTH-1:0]                   sel_i,
  input  dcache_types_pkg::cl_wr_t                                    cl_wr_i,
  input  dcache_types_pkg::word_wr_t                                  word_wr_i,
  output dcache_types_pkg::bank_cmd_t [dcache_cfg_pkg::NUM_BANKS-1:0] bank_cmd_o,
  output logic [dcache_cfg_pkg::NUM_WAYS-1:0]                         tag_req_o,
  output logic                                                        tag_we_o,
  output logic [dcache_cfg_pkg::IDX_WIDTH-1:0]                        tag_idx_o,
  output logic                                                        wr_ack_o
);

  import dcache_cfg_pkg::*;
  import dcache_types_pkg::*;

  rd_port_t                  rd_sel;
  logic [BANK_SEL_WIDTH-1:0] rd_bank;
  logic [BANK_SEL_WIDTH-1:0] wr_bank;
  logic                      refill;
  logic                      rd_data;
  logic                      collide;

  assign rd_sel  = rd_port_i[sel_i];
  assign rd_bank = rd_sel.off[OFF_WIDTH-1:WORD_ALIGN];
  assign wr_bank = word_wr_i.off[OFF_WIDTH-1:WORD_ALIGN];
  assign refill  = cl_wr_i.vld;

  // tag-only reads leave the data banks free
  assign rd_data = rd_acked_i & ~rd_sel.tag_only;
  assign collide = rd_data & (rd_bank == wr_bank);

  always_comb begin
    wr_ack_o = 1'b0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_cmd_o[b].req   = 1'b0;
      bank_cmd_o[b].we    = 1'b0;
      bank_cmd_o[b].idx   = word_wr_i.idx;
      bank_cmd_o[b].wdata = {NUM_WAYS{word_wr_i.data}};
      bank_cmd_o[b].be    = '0;
    end

    if (refill) begin
      // every bank takes its slice of the line
      for (int b = 0; b < NUM_BANKS; b++) begin
        bank_cmd_o[b].req = 1'b1;
        bank_cmd_o[b].we  = 1'b1;
        bank_cmd_o[b].idx = cl_wr_i.idx;
        for (int w = 0; w < NUM_WAYS; w++) begin
          bank_cmd_o[b].wdata[w] = cl_wr_i.data.words[b];
          bank_cmd_o[b].be[w]    = cl_wr_i.we[w] ? cl_wr_i.be.banks[b] : '0;
        end
      end
    end else begin
      if (rd_data) begin
        bank_cmd_o[rd_bank].req = 1'b1;
        bank_cmd_o[rd_bank].idx = rd_sel.idx;
      end
      // word write goes in parallel unless it needs the read bank
      if ((|word_wr_i.req) && !collide) begin
        wr_ack_o                = 1'b1;
        bank_cmd_o[wr_bank].req = 1'b1;
        bank_cmd_o[wr_bank].we  = 1'b1;
        bank_cmd_o[wr_bank].idx = word_wr_i.idx;
        for (int w = 0; w < NUM_WAYS; w++) begin
          bank_cmd_o[wr_bank].be[w] = word_wr_i.req[w] ? word_wr_i.be : '0;
        end
      end
    end
  end

  // tags are read on every grant and written with the refill way mask
  assign tag_req_o = refill ? cl_wr_i.we : {NUM_WAYS{rd_acked_i}};
  assign tag_we_o  = refill;
  assign tag_idx_o = refill ? cl_wr_i.idx : rd_sel.idx;

  // the store unit targets exactly one way
  always_comb begin
    if (wr_ack_o) begin
      a_word_wr_onehot: assert final ($onehot(word_wr_i.req));
    end
  end

endmodule

//--- verilog/dcache_cfg_pkg.sv
////////////////////////////////////////
// dcache config package
// geometry of the L1 data cache memory block
// and the widths derived from it
////////////////////////////////////////

package dcache_cfg_pkg;

  ////////////////////////////////////////
  // array geometry
  ////////////////////////////////////////

  localparam int unsigned NUM_WAYS = 4;
  localparam int unsigned NUM_SETS = 16;
  localparam int unsigned IDX_WIDTH = $clog2(NUM_SETS);

  // one data word per bank
  localparam int unsigned WORD_WIDTH = 64;
  localparam int unsigned WORD_BYTES = WORD_WIDTH / 8;
  localparam int unsigned WORD_ALIGN = $clog2(WORD_BYTES);

  // line and byte offset
  localparam int unsigned LINE_WIDTH = 256;
  localparam int unsigned OFF_WIDTH = $clog2(LINE_WIDTH / 8);

  // bank select sits in the upper offset bits
  localparam int unsigned NUM_BANKS = LINE_WIDTH / WORD_WIDTH;
  localparam int unsigned BANK_SEL_WIDTH = $clog2(NUM_BANKS);

  localparam int unsigned TAG_WIDTH = 8;

  ////////////////////////////////////////
  // read ports
  ////////////////////////////////////////

  localparam int unsigned NUM_PORTS = 3;
  localparam int unsigned PORT_SEL_WIDTH = $clog2(NUM_PORTS);

endpackage

//--- verilog/dcache_hit_sel.sv
////////////////////////////////////////
// dcache hit select
// registers the lookup, compares the late tag
// against every way and muxes the hit word
////////////////////////////////////////

`timescale 1ns/1ps

module dcache_hit_sel (
  input  logic                                                         clk_i,
  input  logic                                                         rst_ni,
  input  logic [dcache_cfg_pkg::IDX_WIDTH-1:0]                         idx_i,
  input  logic [dcache_cfg_pkg::OFF_WIDTH-1:0]                         off_i,
  input  logic [dcache_cfg_pkg::PORT_SEL_WIDTH-1:0]                    sel_i,
  input  logic                                                         cmp_en_i,
  input  logic [dcache_cfg_pkg::NUM_PORTS-1:0][dcache_cfg_pkg::TAG_WIDTH-1:0] rd_tag_i,
  input  logic [dcache_cfg_pkg::NUM_WAYS-1:0][dcache_cfg_pkg::TAG_WIDTH:0]    tag_rdata_i,
  input  logic [dcache_cfg_pkg::NUM_BANKS-1:0][dcache_cfg_pkg::NUM_WAYS-1:0]
               [dcache_cfg_pkg::WORD_WIDTH-1:0]                        bank_rdata_i,
  output logic [dcache_cfg_pkg::NUM_WAYS-1:0]                          rd_vld_bits_o,
  output logic [dcache_cfg_pkg::NUM_WAYS-1:0]                          rd_hit_oh_o,
  output logic [dcache_cfg_pkg::WORD_WIDTH-1:0]                        rd_data_o
);

  import dcache_cfg_pkg::*;

  logic [IDX_WIDTH-1:0]      idx_q;
  logic [OFF_WIDTH-1:0]      off_q;
  logic [PORT_SEL_WIDTH-1:0] sel_q;
  logic                      cmp_en_q;
  logic [TAG_WIDTH-1:0]      rd_tag;
  logic [BANK_SEL_WIDTH-1:0] bank_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q    <= '0;
      off_q    <= '0;
      sel_q    <= '0;
      cmp_en_q <= 1'b0;
    end else begin
      idx_q    <= idx_i;
      off_q    <= off_i;
      sel_q    <= sel_i;
      cmp_en_q <= cmp_en_i;
    end
  end

  // the requester presents its tag one cycle after the ack
  assign rd_tag = rd_tag_i[sel_q];
  assign bank_q = off_q[OFF_WIDTH-1:WORD_ALIGN];

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_cmp
    assign rd_vld_bits_o[w] = tag_rdata_i[w][TAG_WIDTH];
    assign rd_hit_oh_o[w]   = cmp_en_q & rd_vld_bits_o[w] &
                              (tag_rdata_i[w][TAG_WIDTH-1:0] == rd_tag);
  end

  // hit vector is one-hot so an or-tree does the way select
  always_comb begin
    rd_data_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (rd_hit_oh_o[w]) begin
        rd_data_o |= bank_rdata_i[bank_q][w];
      end
    end
  end

  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_hit_oh_o));

  // back to back lookups of one set and tag see the same way since no refill fits between them
  a_hit_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmp_en_q && $past(cmp_en_q) && (idx_q == $past(idx_q)) && (rd_tag == $past(rd_tag))
      |-> rd_hit_oh_o == $past(rd_hit_oh_o));

endmodule

//--- verilog/dcache_mem.sv
////////////////////////////////////////
// dcache memory block
// data banks, tag/valid arrays and the read
// path of the write-through L1 data cache
////////////////////////////////////////

`timescale 1ns/1ps

module dcache_mem (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  dcache_types_pkg::rd_port_t [dcache_cfg_pkg::NUM_PORTS-1:0]  rd_port_i,
  input  logic [dcache_cfg_pkg::NUM_PORTS-1:0][dcache_cfg_pkg::TAG_WIDTH-1:0] rd_tag_i,
  input  dcache_types_pkg::cl_wr_t                                    cl_wr_i,
  input  dcache_types_pkg::word_wr_t                                  word_wr_i,
  output logic [dcache_cfg_pkg::NUM_PORTS-1:0]                        rd_ack_o,
  output logic [dcache_cfg_pkg::NUM_WAYS-1:0]                         rd_vld_bits_o,
  output logic [dcache_cfg_pkg::NUM_WAYS-1:0]                         rd_hit_oh_o,
  output logic [dcache_cfg_pkg::WORD_WIDTH-1:0]                       rd_data_o,
  output logic                                                        wr_ack_o
);

  import dcache_cfg_pkg::*;
  import dcache_types_pkg::*;

  logic                                                 rd_acked;
  logic [PORT_SEL_WIDTH-1:0]                            arb_sel;
  bank_cmd_t [NUM_BANKS-1:0]                            bank_cmd;
  logic [NUM_BANKS-1:0][NUM_WAYS-1:0][WORD_WIDTH-1:0]  bank_rdata;
  logic [NUM_WAYS-1:0]                                  tag_req;
  logic                                                 tag_we;
  logic [IDX_WIDTH-1:0]                                 tag_idx;
  logic [NUM_WAYS-1:0][TAG_WIDTH:0]                     tag_rdata;

  ////////////////////////////////////////
  // arbitration and bank control
  ////////////////////////////////////////

  // a refill holds off every read
  dcache_port_arb i_port_arb (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_port_i  (rd_port_i),
    .stall_i    (cl_wr_i.vld),
    .rd_ack_o   (rd_ack_o),
    .rd_acked_o (rd_acked),
    .sel_o      (arb_sel)
  );

  dcache_bank_ctrl i_bank_ctrl (
    .rd_port_i  (rd_port_i),
    .rd_acked_i (rd_acked),
    .sel_i      (arb_sel),
    .cl_wr_i    (cl_wr_i),
    .word_wr_i  (word_wr_i),
    .bank_cmd_o (bank_cmd),
    .tag_req_o  (tag_req),
    .tag_we_o   (tag_we),
    .tag_idx_o  (tag_idx),
    .wr_ack_o   (wr_ack_o)
  );

  ////////////////////////////////////////
  // arrays
  ////////////////////////////////////////

  // bank b holds word b of the line for all ways
  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_data_bank
    dcache_sram #(
      .WIDTH (NUM_WAYS * WORD_WIDTH),
      .DEPTH (NUM_SETS)
    ) i_data_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (bank_cmd[b].req),
      .we_i    (bank_cmd[b].we),
      .addr_i  (bank_cmd[b].idx),
      .wdata_i (bank_cmd[b].wdata),
      .be_i    (bank_cmd[b].be),
      .rdata_o (bank_rdata[b])
    );
  end

  // valid bit on top of the tag
  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_tag_way
    dcache_sram #(
      .WIDTH (TAG_WIDTH + 1),
      .DEPTH (NUM_SETS)
    ) i_tag_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (tag_req[w]),
      .we_i    (tag_we),
      .addr_i  (tag_idx),
      .wdata_i ({cl_wr_i.vld_bits[w], cl_wr_i.tag}),
      .be_i    ('1),
      .rdata_o (tag_rdata[w])
    );
  end

  ////////////////////////////////////////
  // lookup
  ////////////////////////////////////////

  dcache_hit_sel i_hit_sel (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .idx_i         (rd_port_i[arb_sel].idx),
    .off_i         (rd_port_i[arb_sel].off),
    .sel_i         (arb_sel),
    .cmp_en_i      (rd_acked),
    .rd_tag_i      (rd_tag_i),
    .tag_rdata_i   (tag_rdata),
    .bank_rdata_i  (bank_rdata),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_data_o     (rd_data_o)
  );

endmodule

//--- verilog/dcache_port_arb.sv
////////////////////////////////////////
// dcache read port arbiter
// high priority requests mask low ones,
// equal priority is served round robin
////////////////////////////////////////

`timescale 1ns/1ps

module dcache_port_arb (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  dcache_types_pkg::rd_port_t [dcache_cfg_pkg::NUM_PORTS-1:0] rd_port_i,
  input  logic                                       stall_i,
  output logic [dcache_cfg_pkg::NUM_PORTS-1:0]       rd_ack_o,
  output logic                                       rd_acked_o,
  output logic [dcache_cfg_pkg::PORT_SEL_WIDTH-1:0]  sel_o
);

  import dcache_cfg_pkg::*;

  logic [NUM_PORTS-1:0]      req;
  logic [NUM_PORTS-1:0]      req_prio;
  logic [NUM_PORTS-1:0]      req_masked;
  logic [PORT_SEL_WIDTH-1:0] last_q;
  logic                      found;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_req
    assign req[p]      = rd_port_i[p].req;
    assign req_prio[p] = rd_port_i[p].req & rd_port_i[p].prio;
  end

  // any high prio request hides all low prio ones
  assign req_masked = (|req_prio) ? req_prio : req;

  // first requester after the last granted port
  always_comb begin
    int unsigned cand;
    sel_o = last_q;
    found = 1'b0;
    for (int unsigned i = 1; i <= NUM_PORTS; i++) begin
      cand = (int'(last_q) + i) % NUM_PORTS;
      if (!found && req_masked[cand]) begin
        sel_o = PORT_SEL_WIDTH'(cand);
        found = 1'b1;
      end
    end
  end

  assign rd_acked_o = found & ~stall_i;

  always_comb begin
    rd_ack_o = '0;
    if (rd_acked_o) begin
      rd_ack_o[sel_o] = 1'b1;
    end
  end

  // pointer moves only on a real grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= PORT_SEL_WIDTH'(NUM_PORTS - 1);
    end else if (rd_acked_o) begin
      last_q <= sel_o;
    end
  end

  ////////////////////////////////////////
  // assertions
  ////////////////////////////////////////

  a_ack_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_ack_o) && ((rd_ack_o & ~req_masked) == '0));

  // with an unchanged set of competitors the same port is never granted twice in a row
  a_rr_fair: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_acked_o && ($countones(req_masked) > 1) |=>
      (req_masked != $past(req_masked)) || !rd_acked_o || (rd_ack_o != $past(rd_ack_o)));

endmodule

//--- verilog/dcache_sram.sv
////////////////////////////////////////
// dcache sram
// single port synchronous RAM with byte
// enables and a one cycle read latency
////////////////////////////////////////

`timescale 1ns/1ps

module dcache_sram #(
  parameter int unsigned WIDTH = 64,
  parameter int unsigned DEPTH = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  logic [WIDTH-1:0]         wdata_i,
  input  logic [(WIDTH+7)/8-1:0]   be_i,
  output logic [WIDTH-1:0]         rdata_o
);

  logic [WIDTH-1:0] mem_q [DEPTH];

  // contents start cleared so valid bits read as zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;
      end
      rdata_o <= '0;
    end else if (req_i) begin
      if (we_i) begin
        // last byte lane may be partial
        for (int b = 0; b < WIDTH; b++) begin
          if (be_i[b/8]) begin
            mem_q[addr_i][b] <= wdata_i[b];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

//--- verilog/dcache_types_pkg.sv
////////////////////////////////////////
// dcache types package
// request structs of the read and write ports,
// the per-bank command and the line unions
////////////////////////////////////////

package dcache_types_pkg;

  import dcache_cfg_pkg::*;

  // one read request whose tag follows a cycle later
  typedef struct packed {
    logic                 req;
    logic                 tag_only;
    logic                 prio;
    logic [IDX_WIDTH-1:0] idx;
    logic [OFF_WIDTH-1:0] off;
  } rd_port_t;

  // a line seen flat or as one word per bank
  typedef union packed {
    logic [LINE_WIDTH-1:0]                 bits;
    logic [NUM_BANKS-1:0][WORD_WIDTH-1:0] words;
  } cache_line_u;

  // line byte enables seen flat or per bank
  typedef union packed {
    logic [LINE_WIDTH/8-1:0]               bits;
    logic [NUM_BANKS-1:0][WORD_BYTES-1:0] banks;
  } line_be_u;

  // refill with a way mask in we
  typedef struct packed {
    logic                 vld;
    logic [NUM_WAYS-1:0]  we;
    logic [TAG_WIDTH-1:0] tag;
    logic [IDX_WIDTH-1:0] idx;
    logic [NUM_WAYS-1:0]  vld_bits;
    cache_line_u          data;
    line_be_u             be;
  } cl_wr_t;

  // single word write with a way mask in req
  typedef struct packed {
    logic [NUM_WAYS-1:0]   req;
    logic [IDX_WIDTH-1:0]  idx;
    logic [OFF_WIDTH-1:0]  off;
    logic [WORD_WIDTH-1:0] data;
    logic [WORD_BYTES-1:0] be;
  } word_wr_t;

  // command to one data bank with all ways side by side
  typedef struct packed {
    logic                                 req;
    logic                                 we;
    logic [IDX_WIDTH-1:0]                 idx;
    logic [NUM_WAYS-1:0][WORD_WIDTH-1:0] wdata;
    logic [NUM_WAYS-1:0][WORD_BYTES-1:0] be;
  } bank_cmd_t;

endpackage
